// File: hw/slm_bridge_pkg.sv
package slm_bridge_pkg;

  //////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////

  // one uart byte, or one spi address or data byte
  typedef logic [7:0] byte_t;
  // address byte in the upper half, data byte in the lower half
  typedef logic [15:0] spi_word_t;

  //////////////////////////////////////////////////
  // timing constants
  //////////////////////////////////////////////////

  // 62.5 MHz / 20 gives 3.125 Mbaud on the host link
  localparam int CLKS_PER_BIT = 20;
  // sck half period in fpga_clk cycles
  localparam int SPI_HALF_PERIOD = 4;
  localparam int SPI_BITS = 16;
  // display reset hold after reset_all_cmd_w drops
  localparam int RESET_HOLD_CYCLES = 10;
  localparam int REPLY_DEPTH = 4;

  // counter and pointer widths derived from the constants above
  localparam int UART_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int SPI_CNT_W = $clog2(SPI_HALF_PERIOD);
  localparam int SPI_BIT_W = $clog2(SPI_BITS);
  localparam int RESET_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);
  localparam int REPLY_PTR_W = $clog2(REPLY_DEPTH);
  localparam int REPLY_CNT_W = $clog2(REPLY_DEPTH + 1);

  // shared by the uart receiver and transmitter
  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;
  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spi_state_t;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
  input  logic                  fpga_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  rx_serial_i,
  output logic                  rx_valid_o,
  output slm_bridge_pkg::byte_t rx_byte_o
);
  import slm_bridge_pkg::*;

  // two-flop synchronizer on the async host line
  logic rx_meta_q;
  logic rx_sync_q;

  uart_state_t           state_q;
  logic [UART_CNT_W-1:0] clk_cnt_q;
  logic [2:0]            bit_idx_q;
  byte_t                 shift_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // line idles high
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  //////////////////////////////////////////////////
  // frame fsm
  //////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= UART_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      // single cycle strobe
      rx_valid_o <= 1'b0;
      case (state_q)
        UART_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge marks a start bit
          if (!rx_sync_q) begin
            state_q <= UART_START;
          end
        end
        UART_START: begin
          // half a bit in, confirm start is still low
          if (clk_cnt_q == UART_CNT_W'((CLKS_PER_BIT - 1) / 2)) begin
            clk_cnt_q <= '0;
            state_q   <= rx_sync_q ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            // lsb arrives first, so shift in from the top
            shift_q   <= {rx_sync_q, shift_q[7:1]};
            if (bit_idx_q == 3'd7) begin
              state_q <= UART_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          if (clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q  <= '0;
            // framing error drops the byte silently
            rx_valid_o <= rx_sync_q;
            state_q    <= UART_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  assign rx_byte_o = shift_q;

  // a received byte is announced exactly once
  a_rx_valid_pulse: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    rx_valid_o |=> !rx_valid_o)
    else $error("rx_valid_o held for more than one cycle");

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
  input  logic                  fpga_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  tx_start_i,
  input  slm_bridge_pkg::byte_t tx_byte_i,
  output logic                  tx_serial_o,
  output logic                  tx_active_o
);
  import slm_bridge_pkg::*;

  uart_state_t           state_q;
  logic [UART_CNT_W-1:0] clk_cnt_q;
  logic [2:0]            bit_idx_q;
  // bits still to send, lsb at the bottom
  byte_t                 shift_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= UART_IDLE;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      tx_serial_o <= 1'b1;
      tx_active_o <= 1'b0;
    end else begin
      case (state_q)
        UART_IDLE: begin
          tx_serial_o <= 1'b1;
          clk_cnt_q   <= '0;
          bit_idx_q   <= '0;
          if (tx_start_i) begin
            // start bit goes out on the next cycle
            shift_q     <= tx_byte_i;
            tx_serial_o <= 1'b0;
            tx_active_o <= 1'b1;
            state_q     <= UART_START;
          end
        end
        UART_START: begin
          if (clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q   <= '0;
            tx_serial_o <= shift_q[0];
            state_q     <= UART_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              // stop bit
              tx_serial_o <= 1'b1;
              state_q     <= UART_STOP;
            end else begin
              bit_idx_q   <= bit_idx_q + 1'b1;
              shift_q     <= {1'b0, shift_q[7:1]};
              tx_serial_o <= shift_q[1];
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          // active stays up for the whole stop bit
          if (clk_cnt_q == UART_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q   <= '0;
            tx_active_o <= 1'b0;
            state_q     <= UART_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // the reply fifo must wait for the line to go idle
  a_tx_no_overlap: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    tx_start_i |-> !tx_active_o)
    else $error("tx_start_i arrived while the transmitter was busy");

endmodule

// File: hw/spi_master.sv
`timescale 1ns/1ns

module spi_master (
  input  logic                      fpga_clk,
  input  logic                      reset_all_cmd_w,
  input  logic                      spi_start_i,
  input  slm_bridge_pkg::spi_word_t spi_word_i,
  input  logic                      spi_miso_i,
  output logic                      spi_sen_o,
  output logic                      spi_sck_o,
  output logic                      spi_mosi_o,
  output logic                      reply_valid_o,
  output slm_bridge_pkg::byte_t     reply_byte_o
);
  import slm_bridge_pkg::*;

  spi_state_t           state_q;
  logic [SPI_CNT_W-1:0] half_cnt_q;
  logic [SPI_BIT_W-1:0] bit_cnt_q;
  // outgoing word, msb first
  spi_word_t            tx_shift_q;
  // only the last eight sampled bits are kept
  byte_t                rx_shift_q;

  //////////////////////////////////////////////////
  // mode 0 transfer engine
  //////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= SPI_IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      spi_sen_o  <= 1'b1;
      spi_sck_o  <= 1'b0;
      spi_mosi_o <= 1'b0;
    end else begin
      case (state_q)
        SPI_IDLE: begin
          half_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (spi_start_i) begin
            // chip select drops with the first bit already on sdat
            tx_shift_q <= spi_word_i;
            spi_mosi_o <= spi_word_i[SPI_BITS-1];
            spi_sen_o  <= 1'b0;
            state_q    <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_cnt_q == SPI_CNT_W'(SPI_HALF_PERIOD - 1)) begin
            half_cnt_q <= '0;
            if (!spi_sck_o) begin
              // rising sck, sample miso
              spi_sck_o  <= 1'b1;
              rx_shift_q <= {rx_shift_q[6:0], spi_miso_i};
            end else if (bit_cnt_q == SPI_BIT_W'(SPI_BITS - 1)) begin
              // end of the last high phase
              spi_sck_o  <= 1'b0;
              spi_sen_o  <= 1'b1;
              spi_mosi_o <= 1'b0;
              state_q    <= SPI_DONE;
            end else begin
              // falling sck, next bit onto sdat
              spi_sck_o  <= 1'b0;
              bit_cnt_q  <= bit_cnt_q + 1'b1;
              tx_shift_q <= {tx_shift_q[SPI_BITS-2:0], 1'b0};
              spi_mosi_o <= tx_shift_q[SPI_BITS-2];
            end
          end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
          end
        end
        // one cycle for the reply strobe
        SPI_DONE: state_q <= SPI_IDLE;
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // reply valid in the same cycle sen goes back high
  assign reply_valid_o = (state_q == SPI_DONE);
  assign reply_byte_o  = rx_shift_q;

  // the pairer cannot issue back to back frames
  a_start_when_idle: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    spi_start_i |-> state_q == SPI_IDLE)
    else $error("spi_start_i arrived while a transfer was running");

  a_sck_idle_low: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    spi_sen_o |-> !spi_sck_o)
    else $error("sck toggled with sen deasserted");

endmodule

// File: hw/cmd_pairer.sv
`timescale 1ns/1ns

module cmd_pairer (
  input  logic                      fpga_clk,
  input  logic                      reset_all_cmd_w,
  input  logic                      rx_valid_i,
  input  slm_bridge_pkg::byte_t     rx_byte_i,
  output logic                      spi_start_o,
  output slm_bridge_pkg::spi_word_t spi_word_o
);
  import slm_bridge_pkg::*;

  // older byte on top, newest byte at the bottom
  spi_word_t pair_q;
  // high once the address half of a pair is in
  logic      addr_seen_q;

  //////////////////////////////////////////////////
  // byte holding register
  //////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i) begin
      pair_q <= {pair_q[7:0], rx_byte_i};
    end
  end

  //////////////////////////////////////////////////
  // odd/even tracking and frame trigger
  //////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // first byte after reset is an address
      addr_seen_q <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= 1'b0;
      if (rx_valid_i) begin
        addr_seen_q <= !addr_seen_q;
        // data byte completes the pair
        if (addr_seen_q) begin
          spi_start_o <= 1'b1;
        end
      end
    end
  end

  // pair_q already holds address over data when the start goes out
  assign spi_word_o = pair_q;

endmodule

// File: hw/reply_fifo.sv
`timescale 1ns/1ns

module reply_fifo (
  input  logic                  fpga_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  wr_valid_i,
  input  slm_bridge_pkg::byte_t wr_byte_i,
  input  logic                  tx_active_i,
  output logic                  tx_start_o,
  output slm_bridge_pkg::byte_t tx_byte_o
);
  import slm_bridge_pkg::*;

  byte_t                  mem_q [REPLY_DEPTH];
  logic [REPLY_PTR_W-1:0] wr_ptr_q;
  logic [REPLY_PTR_W-1:0] rd_ptr_q;
  logic [REPLY_CNT_W-1:0] count_q;
  logic                   rd_strobe_q;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   wr_en;

  assign fifo_full  = (count_q == REPLY_CNT_W'(REPLY_DEPTH));
  assign fifo_empty = (count_q == '0);
  // replies that find the buffer full are lost
  assign wr_en      = wr_valid_i && !fifo_full;

  // storage and head register
  always_ff @(posedge fpga_clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_byte_i;
    end
    if (rd_strobe_q) begin
      tx_byte_o <= mem_q[rd_ptr_q];
    end
  end

  //////////////////////////////////////////////////
  // pointers and drain sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      rd_strobe_q <= 1'b0;
      tx_start_o  <= 1'b0;
    end else begin
      // hold off until tx_active_i reflects the byte just started
      rd_strobe_q <= !fifo_empty && !tx_active_i && !rd_strobe_q && !tx_start_o;
      tx_start_o  <= rd_strobe_q;
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_strobe_q) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_strobe_q})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    count_q <= REPLY_CNT_W'(REPLY_DEPTH))
    else $error("reply fifo count above its depth");

endmodule

// File: hw/slm_bridge_top.sv
`timescale 1ns/1ns

module slm_bridge_top (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  input  logic spi_sout_i,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  output logic slm_reset_n_o
);
  import slm_bridge_pkg::*;

  logic      rx_valid;
  byte_t     rx_byte;
  logic      spi_start;
  spi_word_t spi_word;
  logic      reply_valid;
  byte_t     reply_byte;
  logic      tx_start;
  byte_t     tx_byte;
  logic      tx_active;

  logic [RESET_CNT_W-1:0] hold_cnt_q;

  //////////////////////////////////////////////////
  // display reset stretcher
  //////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // reload for the whole time reset is asserted
      hold_cnt_q    <= RESET_CNT_W'(RESET_HOLD_CYCLES);
      slm_reset_n_o <= 1'b0;
    end else begin
      // display leaves reset once the count runs out
      slm_reset_n_o <= (hold_cnt_q == '0);
      if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // command path, host -> spi -> host
  //////////////////////////////////////////////////

  uart_rx u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  // address byte then data byte
  cmd_pairer u_cmd_pairer (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word)
  );

  spi_master u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_start_i     (spi_start),
    .spi_word_i      (spi_word),
    .spi_miso_i      (spi_sout_i),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_sdat_o),
    .reply_valid_o   (reply_valid),
    .reply_byte_o    (reply_byte)
  );

  reply_fifo u_reply_fifo (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .wr_valid_i      (reply_valid),
    .wr_byte_i       (reply_byte),
    .tx_active_i     (tx_active),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_serial_o     (uart_tx_o),
    .tx_active_o     (tx_active)
  );

endmodule

// File: sim/spi_slave_model.sv
`timescale 1ns/1ns

module spi_slave_model (
  input  logic        sen_i,
  input  logic        sck_i,
  input  logic        mosi_i,
  output logic        miso_o,
  output logic [15:0] frame_word_o,
  output int          frame_edges_o,
  output int          frame_count_o
);

  logic [15:0] shift_reg = '0;
  // inverted address, sent back msb first
  logic [7:0]  reply_reg = '0;
  logic        miso_reg = 1'b0;
  int          edge_cnt = 0;
  int          start_cnt = 0;
  logic [15:0] word_out = '0;
  int          edges_out = 0;
  int          frame_cnt = 0;

  //////////////////////////////////////////////////
  // capture on rising sck, restart on falling sen
  //////////////////////////////////////////////////

  always @(negedge sen_i or posedge sck_i) begin
    if (sck_i) begin
      shift_reg = {shift_reg[14:0], mosi_i};
      edge_cnt  = edge_cnt + 1;
    end else begin
      shift_reg = '0;
      edge_cnt  = 0;
      start_cnt = start_cnt + 1;
    end
  end

  // reply bits change while sck is low
  always @(negedge sck_i) begin
    if (edge_cnt == 8) begin
      // address byte is complete in the low half
      reply_reg = ~shift_reg[7:0];
    end
    if (edge_cnt >= 8 && edge_cnt < 16) begin
      miso_reg  = reply_reg[7];
      reply_reg = {reply_reg[6:0], 1'b0};
    end else begin
      miso_reg = 1'b0;
    end
  end

  // end of frame, publish the word and its edge count
  always @(posedge sen_i) begin
    if (start_cnt != frame_cnt) begin
      word_out  = shift_reg;
      edges_out = edge_cnt;
      frame_cnt = frame_cnt + 1;
    end
  end

  assign miso_o        = miso_reg;
  assign frame_word_o  = word_out;
  assign frame_edges_o = edges_out;
  assign frame_count_o = frame_cnt;

endmodule

// File: sim/tb_slm_bridge.sv
`timescale 1ns/1ns

module tb_slm_bridge;
  import slm_bridge_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_PAIRS = 8;
  // one pair, its frame and its reply fit well inside this
  localparam int PAIR_CYCLES = 800;
  localparam int WATCHDOG_NS = (NUM_PAIRS * PAIR_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  logic        fpga_clk;
  logic        reset_all_cmd_w;
  logic        uart_rx;
  logic        uart_tx;
  logic        spi_sout;
  logic        spi_sen;
  logic        spi_sck;
  logic        spi_sdat;
  logic        slm_reset_n;
  logic [15:0] frame_word;
  int          frame_edges;
  int          frame_count;

  // scoreboard
  spi_word_t   exp_words[$];
  byte_t       exp_replies[$];
  int          frames_checked = 0;
  int          replies_seen = 0;
  logic [15:0] lfsr_state;

  slm_bridge_top u_slm_bridge_top (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx),
    .uart_tx_o       (uart_tx),
    .spi_sout_i      (spi_sout),
    .spi_sen_o       (spi_sen),
    .spi_sck_o       (spi_sck),
    .spi_sdat_o      (spi_sdat),
    .slm_reset_n_o   (slm_reset_n)
  );

  // display controller, answers with the inverted address
  spi_slave_model u_spi_slave_model (
    .sen_i         (spi_sen),
    .sck_i         (spi_sck),
    .mosi_i        (spi_sdat),
    .miso_o        (spi_sout),
    .frame_word_o  (frame_word),
    .frame_edges_o (frame_edges),
    .frame_count_o (frame_count)
  );

  initial begin
    fpga_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fpga_clk = ~fpga_clk;
  end

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp)
      else begin
        $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
        stop_run();
      end
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic random_byte(output byte_t value);
    value = '0;
    // one lfsr step per bit
    repeat (8) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {lfsr_state[0], value[7:1]};
    end
  endtask

  // host side 8n1, entered and left 1 ns after a rising edge
  task automatic send_host_byte(input byte_t value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int b = 0; b < 10; b++) begin
      uart_rx = frame[b];
      repeat (CLKS_PER_BIT) @(posedge fpga_clk);
      #1;
    end
  endtask

  task automatic wait_for_replies(input int count, input int limit);
    int waited;
    waited = 0;
    while (replies_seen < count) begin
      if (waited == limit) begin
        report_problem("reply bytes did not come back from the DUT in time");
      end
      @(posedge fpga_clk);
      #1;
      waited++;
    end
  endtask

  //////////////////////////////////////////////////
  // protocol checks
  //////////////////////////////////////////////////

  a_reset_levels: assert property (@(posedge fpga_clk)
    reset_all_cmd_w |=> (!slm_reset_n && spi_sen && !spi_sck && uart_tx))
    else report_problem("outputs left their reset levels while reset was held");

  a_sck_low_idle: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    spi_sen |-> !spi_sck)
    else report_problem("SCK was high while SEN was deasserted");

  a_sdat_stable: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    $rose(spi_sck) |-> $stable(spi_sdat))
    else report_problem("SDAT changed at a rising SCK edge");

  // frames are looked at half a clock after sen rises
  always @(negedge fpga_clk) begin
    if (frame_count != frames_checked) begin
      frames_checked = frames_checked + 1;
      if (exp_words.size() == 0) begin
        report_problem("an SPI frame started without a complete byte pair");
      end else begin
        check_value("spi_sdat_o word", int'(frame_word), int'(exp_words.pop_front()));
      end
      check_value("spi_sck_o rising edges", frame_edges, SPI_BITS);
    end
  end

  // decodes uart_tx_o, every bit sampled on each of its cycles
  initial begin : reply_monitor
    byte_t value;
    logic  level;
    value = '0;
    level = 1'b1;
    forever begin
      @(negedge fpga_clk);
      if (!reset_all_cmd_w && uart_tx === 1'b0) begin
        for (int b = 0; b < 10; b++) begin
          if (b > 0) begin
            @(negedge fpga_clk);
          end
          level = uart_tx;
          for (int c = 1; c < CLKS_PER_BIT; c++) begin
            @(negedge fpga_clk);
            if (uart_tx !== level) begin
              report_problem("a reply bit on uart_tx_o was not CLKS_PER_BIT cycles wide");
            end
          end
          if (b >= 1 && b <= 8) begin
            value = {level, value[7:1]};
          end
        end
        check_value("uart_tx_o stop bit", int'(level), 1);
        if (exp_replies.size() == 0) begin
          report_problem("a reply byte arrived with no pair pending");
        end else begin
          check_value("uart_tx_o reply byte", int'(value), int'(exp_replies.pop_front()));
        end
        replies_seen = replies_seen + 1;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_problem("watchdog expired before the tests finished");
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : main_seq
    byte_t addr;
    byte_t data;
    int    low_cycles;
    reset_all_cmd_w = 1'b1;
    uart_rx         = 1'b1;
    lfsr_state      = 16'd7094;
    repeat (RESET_CYCLES) @(posedge fpga_clk);
    #1;
    reset_all_cmd_w = 1'b0;

    // idle levels right after reset
    check_value("spi_sen_o", int'(spi_sen), 1);
    check_value("spi_sck_o", int'(spi_sck), 0);
    check_value("uart_tx_o", int'(uart_tx), 1);

    // display reset hold, counted from the first edge with reset low
    low_cycles = 0;
    @(posedge fpga_clk);
    #1;
    while (!slm_reset_n && low_cycles <= RESET_HOLD_CYCLES + 2) begin
      low_cycles++;
      @(posedge fpga_clk);
      #1;
    end
    check_value("slm_reset_n_o low cycles", low_cycles, RESET_HOLD_CYCLES);

    // lone address byte, no frame yet
    random_byte(addr);
    random_byte(data);
    send_host_byte(addr);
    repeat (2 * (1 + SPI_BITS * 2 * SPI_HALF_PERIOD)) @(posedge fpga_clk);
    #1;
    check_value("spi frame count", frame_count, 0);

    // data byte completes the pair
    exp_words.push_back({addr, data});
    exp_replies.push_back(~addr);
    send_host_byte(data);
    wait_for_replies(1, PAIR_CYCLES);
    check_value("spi frame count", frame_count, 1);

    // random pairs back to back
    for (int i = 0; i < NUM_PAIRS; i++) begin
      random_byte(addr);
      random_byte(data);
      exp_words.push_back({addr, data});
      exp_replies.push_back(~addr);
      send_host_byte(addr);
      send_host_byte(data);
    end
    wait_for_replies(NUM_PAIRS + 1, PAIR_CYCLES);
    check_value("spi frame count", frame_count, NUM_PAIRS + 1);

    repeat (4 * CLKS_PER_BIT) @(posedge fpga_clk);
    if (exp_words.size() != 0 || exp_replies.size() != 0 || replies_seen != NUM_PAIRS + 1) begin
      report_problem("SPI frames or reply bytes went missing or came extra");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: list.f
hw/slm_bridge_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/spi_master.sv
hw/cmd_pairer.sv
hw/reply_fifo.sv
hw/slm_bridge_top.sv
sim/spi_slave_model.sv
sim/tb_slm_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

# the run passes only if the pass line shows up in the simulator output
verilator --binary --timing --assert \
  --top-module tb_slm_bridge -f list.f -o tb_slm_bridge \
  && ./obj_dir/tb_slm_bridge | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
